/* Bender.yml */
package:
  name: cache_bank

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/cache_req_if.sv
      - hw/intra_bank_arbiter.sv
      - hw/request_queue.sv
      - hw/cache_set_array.sv
      - hw/cache_bank_ctrl.sv
      - hw/cache_bank.sv
  - target: test
    files:
      - tb/cache_checker.sv
      - tb/tb_cache_bank.sv

/* hw/cache_bank.sv */
`timescale 1ns/1ps

module cache_bank (
    input  logic                                                 clk_in,
    input  logic                                                 rst_n,
    input  logic [cache_pkg::NUM_INPUT_PORT*cache_pkg::PKT_W-1:0] req_pkt,
    input  logic [cache_pkg::NUM_INPUT_PORT-1:0]                  req_valid,
    input  logic [cache_pkg::NUM_INPUT_PORT-1:0]                  req_critical,
    output logic [cache_pkg::NUM_INPUT_PORT-1:0]                  req_ack,
    output logic [cache_pkg::PKT_W-1:0]                           miss_pkt,
    output logic                                                 miss_valid,
    input  logic                                                 miss_ack,
    output logic [cache_pkg::PKT_W-1:0]                           wb_pkt,
    output logic                                                 wb_valid,
    input  logic                                                 wb_ack,
    input  logic [cache_pkg::PKT_W-1:0]                           fetched_pkt,
    input  logic                                                 fetched_valid,
    output logic                                                 fetch_ack,
    output logic [cache_pkg::PKT_W-1:0]                           ret_pkt,
    output logic                                                 ret_valid,
    input  logic                                                 ret_ack
);

    cache_pkg::cache_pkt_t req_arr [cache_pkg::NUM_INPUT_PORT];

    cache_req_if arb_to_q ();
    cache_req_if q_to_ctrl ();

    // port i sits at bits [i*PKT_W +: PKT_W]
    for (genvar i = 0; i < cache_pkg::NUM_INPUT_PORT; i++)
    begin : g_unpack
        assign req_arr[i] = req_pkt[i*cache_pkg::PKT_W +: cache_pkg::PKT_W];
    end

    intra_bank_arbiter i_arbiter (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .req_pkt      (req_arr),
        .req_valid    (req_valid),
        .req_critical (req_critical),
        .req_ack      (req_ack),
        .out          (arb_to_q.src)
    );

    request_queue i_queue (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .in     (arb_to_q.dst),
        .out    (q_to_ctrl.src)
    );

    cache_bank_ctrl i_ctrl (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .req           (q_to_ctrl.dst),
        .miss_pkt      (miss_pkt),
        .wb_pkt        (wb_pkt),
        .ret_pkt       (ret_pkt),
        .miss_valid    (miss_valid),
        .wb_valid      (wb_valid),
        .ret_valid     (ret_valid),
        .miss_ack      (miss_ack),
        .wb_ack        (wb_ack),
        .ret_ack       (ret_ack),
        .fetched_pkt   (fetched_pkt),
        .fetched_valid (fetched_valid),
        .fetch_ack     (fetch_ack)
    );

endmodule

/* hw/cache_bank_ctrl.sv */
`timescale 1ns/1ps

module cache_bank_ctrl (
    input  logic                  clk_in,
    input  logic                  rst_n,
    cache_req_if.dst              req,
    output cache_pkg::cache_pkt_t miss_pkt,
    output cache_pkg::cache_pkt_t wb_pkt,
    output cache_pkg::cache_pkt_t ret_pkt,
    output logic                  miss_valid,
    output logic                  wb_valid,
    output logic                  ret_valid,
    input  logic                  miss_ack,
    input  logic                  wb_ack,
    input  logic                  ret_ack,
    input  cache_pkg::cache_pkt_t fetched_pkt,
    input  logic                  fetched_valid,
    output logic                  fetch_ack
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_MISS,
        S_FILL,
        S_RESPOND
    } state_t;

    state_t                          state;
    cache_pkg::cache_pkt_t           cur_q;
    logic [cache_pkg::SET_IDX_W-1:0] set_idx;
    logic [cache_pkg::TAG_W-1:0]     cur_tag;
    logic                            hit;
    logic                            hit_way;
    logic                            victim_way;
    logic                            victim_dirty;
    logic                            victim_valid;
    logic [cache_pkg::TAG_W-1:0]     victim_tag;
    logic [cache_pkg::DATA_W-1:0]    read_data;
    logic [cache_pkg::DATA_W-1:0]    word_data;
    logic                            write_en;
    logic                            touch;

    assign set_idx = cache_pkg::set_of(cur_q.addr);
    assign cur_tag = cache_pkg::tag_of(cur_q.addr);

    // pop only when idle so one request is in progress at a time
    assign req.ack    = (state == S_IDLE) && req.valid;
    assign wb_valid   = state == S_WRITEBACK;
    assign miss_valid = state == S_MISS;
    assign fetch_ack  = state == S_FILL;
    assign ret_valid  = state == S_RESPOND;

    // write data wins, else fetched word on a fill, else the array word
    assign word_data = cur_q.write ? cur_q.data :
                       (state == S_FILL) ? fetched_pkt.data : read_data;

    assign write_en = ((state == S_LOOKUP) && hit && cur_q.write) ||
                      ((state == S_FILL) && fetched_valid);
    assign touch    = ((state == S_LOOKUP) && hit) ||
                      ((state == S_FILL) && fetched_valid);

    // array is untouched until the fill, so the victim stays put
    always_comb
    begin
        miss_pkt       = cur_q;
        miss_pkt.data  = '0;
        miss_pkt.write = 1'b0;
        wb_pkt.addr    = cache_pkg::block_addr(victim_tag, set_idx);
        wb_pkt.data    = read_data;
        wb_pkt.write   = 1'b1;
        wb_pkt.port    = cur_q.port;
    end

    cache_set_array i_array (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .set_idx      (set_idx),
        .lookup_tag   (cur_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag),
        .read_data    (read_data),
        .write_en     (write_en),
        .write_way    (hit ? hit_way : victim_way),
        .write_tag    (cur_tag),
        .write_data   (word_data),
        .write_dirty  (cur_q.write),
        .touch        (touch)
    );

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                    if (req.valid)
                        state <= S_LOOKUP;
                S_LOOKUP:
                    if (hit)
                        state <= S_RESPOND;
                    else if (victim_valid && victim_dirty)
                        state <= S_WRITEBACK;
                    else
                        state <= S_MISS;
                S_WRITEBACK:
                    if (wb_ack)
                        state <= S_MISS;
                S_MISS:
                    if (miss_ack)
                        state <= S_FILL;
                S_FILL:
                    if (fetched_valid)
                        state <= S_RESPOND;
                S_RESPOND:
                    if (ret_ack)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (req.ack)
            cur_q <= req.pkt;
        if (touch)
        begin
            ret_pkt      <= cur_q;
            ret_pkt.data <= word_data;
        end
    end

    a_fill_addr: assert property (@(posedge clk_in) disable iff (!rst_n)
        fetched_valid && fetch_ack |-> fetched_pkt.addr == cur_q.addr);

    // the returned word is what the array now holds for this address
    a_ret_cached: assert property (@(posedge clk_in) disable iff (!rst_n)
        ret_valid |-> hit && read_data == ret_pkt.data);

endmodule

/* hw/cache_pkg.sv */
package cache_pkg;

    localparam int NUM_INPUT_PORT = 2;
    localparam int NUM_SET        = 4;
    localparam int NUM_WAY        = 2;
    localparam int SET_IDX_W      = 2;
    localparam int ADDR_W         = 16;
    localparam int TAG_W          = ADDR_W - SET_IDX_W;
    localparam int DATA_W         = 32;
    localparam int PORT_ID_W      = 1;
    localparam int QUEUE_DEPTH    = 4;

    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
        logic                 write;
        logic [PORT_ID_W-1:0] port;
    } cache_pkt_t;

    localparam int PKT_W = $bits(cache_pkt_t);

    // word address = {tag, set index}
    function automatic logic [SET_IDX_W-1:0] set_of(input logic [ADDR_W-1:0] addr);
        return addr[SET_IDX_W-1:0];
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:SET_IDX_W];
    endfunction

    function automatic logic [ADDR_W-1:0] block_addr(
        input logic [TAG_W-1:0]     tag,
        input logic [SET_IDX_W-1:0] set_idx
    );
        return {tag, set_idx};
    endfunction

endpackage

/* hw/cache_req_if.sv */
`timescale 1ns/1ps

interface cache_req_if;

    logic                  valid;
    logic                  ack;
    logic                  critical;
    cache_pkg::cache_pkt_t pkt;

    // source holds valid, pkt and critical until it sees ack
    modport src (output valid, output pkt, output critical, input ack);
    modport dst (input valid, input pkt, input critical, output ack);

endinterface

/* hw/cache_set_array.sv */
`timescale 1ns/1ps

module cache_set_array (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic [cache_pkg::SET_IDX_W-1:0] set_idx,
    input  logic [cache_pkg::TAG_W-1:0]     lookup_tag,
    output logic                            hit,
    output logic                            hit_way,
    output logic                            victim_way,
    output logic                            victim_dirty,
    output logic                            victim_valid,
    output logic [cache_pkg::TAG_W-1:0]     victim_tag,
    output logic [cache_pkg::DATA_W-1:0]    read_data,
    input  logic                            write_en,
    input  logic                            write_way,
    input  logic [cache_pkg::TAG_W-1:0]     write_tag,
    input  logic [cache_pkg::DATA_W-1:0]    write_data,
    input  logic                            write_dirty,
    input  logic                            touch
);

    logic [cache_pkg::NUM_SET-1:0][cache_pkg::NUM_WAY-1:0] valid_q;
    logic [cache_pkg::NUM_SET-1:0][cache_pkg::NUM_WAY-1:0] dirty_q;
    logic [cache_pkg::TAG_W-1:0]  tag_q  [cache_pkg::NUM_SET][cache_pkg::NUM_WAY];
    logic [cache_pkg::DATA_W-1:0] data_q [cache_pkg::NUM_SET][cache_pkg::NUM_WAY];
    // history names the next victim when both ways are valid
    logic [cache_pkg::NUM_SET-1:0] hist_q;
    logic [cache_pkg::NUM_WAY-1:0] way_hit;

    always_comb
    begin
        for (int w = 0; w < cache_pkg::NUM_WAY; w++)
        begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == lookup_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    always_comb
    begin
        if (!valid_q[set_idx][0])
            victim_way = 1'b0;
        else if (!valid_q[set_idx][1])
            victim_way = 1'b1;
        else
            victim_way = hist_q[set_idx];
    end

    assign victim_valid = valid_q[set_idx][victim_way];
    assign victim_dirty = victim_valid && dirty_q[set_idx][victim_way];
    assign victim_tag   = tag_q[set_idx][victim_way];
    assign read_data    = data_q[set_idx][hit ? hit_way : victim_way];

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            hist_q  <= '0;
        end
        else
        begin
            if (write_en)
            begin
                valid_q[set_idx][write_way] <= 1'b1;
                dirty_q[set_idx][write_way] <= write_dirty;
            end
            if (touch)
                hist_q[set_idx] <= ~write_way;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (write_en)
        begin
            tag_q[set_idx][write_way]  <= write_tag;
            data_q[set_idx][write_way] <= write_data;
        end
    end

    // the controller never fills a tag that is already present
    a_single_hit: assert property (@(posedge clk_in) disable iff (!rst_n) !(&way_hit));

endmodule

/* hw/intra_bank_arbiter.sv */
`timescale 1ns/1ps

module intra_bank_arbiter (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  cache_pkg::cache_pkt_t               req_pkt [cache_pkg::NUM_INPUT_PORT],
    input  logic [cache_pkg::NUM_INPUT_PORT-1:0] req_valid,
    input  logic [cache_pkg::NUM_INPUT_PORT-1:0] req_critical,
    output logic [cache_pkg::NUM_INPUT_PORT-1:0] req_ack,
    cache_req_if.src                            out
);

    logic [cache_pkg::NUM_INPUT_PORT-1:0] cand;
    logic [cache_pkg::NUM_INPUT_PORT-1:0] grant;
    logic [cache_pkg::PORT_ID_W-1:0]      win_idx;
    cache_pkg::cache_pkt_t                win_pkt;
    logic                                 slot_free;

    // critical requests mask the others
    assign cand = (|(req_valid & req_critical)) ? (req_valid & req_critical) : req_valid;

    // later iterations override, so the highest index wins
    always_comb
    begin
        grant   = '0;
        win_idx = '0;
        for (int i = 0; i < cache_pkg::NUM_INPUT_PORT; i++)
        begin
            if (cand[i])
            begin
                grant    = '0;
                grant[i] = 1'b1;
                win_idx  = i[cache_pkg::PORT_ID_W-1:0];
            end
        end
        win_pkt      = req_pkt[win_idx];
        win_pkt.port = win_idx;
    end

    assign slot_free = !out.valid || out.ack;
    assign req_ack   = slot_free ? grant : '0;

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
            out.valid <= 1'b0;
        else if (slot_free)
            out.valid <= |cand;
    end

    always_ff @(posedge clk_in)
    begin
        if (slot_free)
        begin
            out.pkt      <= win_pkt;
            out.critical <= req_critical[win_idx];
        end
    end

    a_ack_onehot: assert property (@(posedge clk_in) disable iff (!rst_n) $onehot0(req_ack));

endmodule

/* hw/request_queue.sv */
`timescale 1ns/1ps

module request_queue #(
    parameter int DEPTH = cache_pkg::QUEUE_DEPTH
) (
    input  logic     clk_in,
    input  logic     rst_n,
    cache_req_if.dst in,
    cache_req_if.src out
);

    localparam int PTR_W = $clog2(DEPTH);

    cache_pkg::cache_pkt_t pkt_mem [DEPTH];
    logic [DEPTH-1:0]      crit_mem;
    // extra msb tells full from empty
    logic [PTR_W:0]        wr_ptr;
    logic [PTR_W:0]        rd_ptr;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign in.ack    = !full;
    assign out.valid = wr_ptr != rd_ptr;
    assign push      = in.valid && in.ack;
    assign pop       = out.valid && out.ack;

    // show-ahead head entry
    assign out.pkt      = pkt_mem[rd_ptr[PTR_W-1:0]];
    assign out.critical = crit_mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk_in)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (push)
        begin
            pkt_mem[wr_ptr[PTR_W-1:0]]  <= in.pkt;
            crit_mem[wr_ptr[PTR_W-1:0]] <= in.critical;
        end
    end

    // a push refused while full is retried with the same packet
    a_no_push_full: assert property (@(posedge clk_in) disable iff (!rst_n)
        in.valid && full |=> in.valid && $stable(in.pkt));

    a_no_pop_empty: assert property (@(posedge clk_in) disable iff (!rst_n)
        out.ack |-> out.valid);

endmodule

/* tb/cache_cases.txt */
// id port crit write addr data expect miss wb wb_addr wb_data stall (all hex)
// lines with one id form a test and are listed in the order the returns must arrive
1 0 0 0 0010 00000000 5a5a0010 1 0 0000 00000000 0
1 0 0 0 0010 00000000 5a5a0010 0 0 0000 00000000 0
2 1 0 1 0021 cafe0001 cafe0001 1 0 0000 00000000 0
2 1 0 0 0021 00000000 cafe0001 0 0 0000 00000000 0
3 0 0 1 0102 11110102 11110102 1 0 0000 00000000 0
3 0 0 1 0202 22220202 22220202 1 0 0000 00000000 0
3 0 0 0 0302 00000000 5a5a0302 1 1 0102 11110102 0
3 0 0 0 0102 00000000 11110102 1 1 0202 22220202 0
3 0 0 0 0202 00000000 22220202 1 0 0000 00000000 0
4 0 1 0 0013 00000000 5a5a0013 1 0 0000 00000000 0
4 1 0 0 0023 00000000 5a5a0023 1 0 0000 00000000 0
5 1 0 0 0023 00000000 5a5a0023 0 0 0000 00000000 0
5 0 0 0 0013 00000000 5a5a0013 0 0 0000 00000000 0
6 1 0 0 0010 00000000 5a5a0010 0 0 0000 00000000 28
6 1 0 1 0031 33330031 33330031 1 0 0000 00000000 0
6 1 0 0 0041 00000000 5a5a0041 1 1 0021 cafe0001 0
6 1 0 0 0021 00000000 cafe0001 1 1 0031 33330031 0
6 0 0 1 0010 44440010 44440010 0 0 0000 00000000 0
6 0 0 0 0031 00000000 33330031 1 0 0000 00000000 0
6 0 0 0 0010 00000000 44440010 0 0 0000 00000000 0

/* tb/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
    input logic                  clk_in,
    input logic                  rst_n,
    input cache_pkg::cache_pkt_t ret_pkt,
    input logic                  ret_valid,
    input logic                  ret_ack,
    input cache_pkg::cache_pkt_t miss_pkt,
    input logic                  miss_valid,
    input logic                  miss_ack,
    input cache_pkg::cache_pkt_t wb_pkt,
    input logic                  wb_valid,
    input logic                  wb_ack,
    input logic                  fetched_valid,
    input logic                  fetch_ack
);

    typedef struct packed {
        logic [cache_pkg::ADDR_W-1:0]    addr;
        logic [cache_pkg::DATA_W-1:0]    data;
        logic [cache_pkg::PORT_ID_W-1:0] port;
        logic                            miss;
        logic                            wb;
        logic [cache_pkg::ADDR_W-1:0]    wb_addr;
        logic [cache_pkg::DATA_W-1:0]    wb_data;
    } exp_ret_t;

    exp_ret_t exp_q [$];
    exp_ret_t head;
    // miss and writeback transfers seen since the last return
    int       miss_seen;
    int       wb_seen;
    int       error_count;
    // set between a miss transfer and its fill
    logic     fill_pending;

    initial
    begin
        miss_seen    = 0;
        wb_seen      = 0;
        error_count  = 0;
        fill_pending = 1'b0;
    end

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    task automatic expect_ret(
        input logic [cache_pkg::ADDR_W-1:0] addr,
        input logic [cache_pkg::DATA_W-1:0] data,
        input logic                         port,
        input logic                         miss,
        input logic                         wb,
        input logic [cache_pkg::ADDR_W-1:0] wb_addr,
        input logic [cache_pkg::DATA_W-1:0] wb_data
    );
        exp_ret_t e;
        e.addr    = addr;
        e.data    = data;
        e.port    = port;
        e.miss    = miss;
        e.wb      = wb;
        e.wb_addr = wb_addr;
        e.wb_data = wb_data;
        exp_q.push_back(e);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // the controller serves one request at a time, so the queue head owns
    // every miss and writeback until its return comes back
    always @(posedge clk_in)
    begin
        if (rst_n)
        begin
            if (fetch_ack && !fill_pending)
            begin
                $display("fetch_ack is high at %0t ns with no miss request outstanding",
                         $time);
                error_count++;
            end
            if (fetched_valid && !fetch_ack)
            begin
                $display("fetched packet was not taken at %0t ns", $time);
                error_count++;
            end
            if (fetched_valid && fetch_ack)
                fill_pending = 1'b0;
            if (wb_valid && wb_ack)
            begin
                wb_seen++;
                if (exp_q.size() > 0 && exp_q[0].wb)
                begin
                    compare_field("wb_pkt.addr", 32'(wb_pkt.addr), 32'(exp_q[0].wb_addr));
                    compare_field("wb_pkt.data", wb_pkt.data, exp_q[0].wb_data);
                end
            end
            if (miss_valid && miss_ack)
            begin
                miss_seen++;
                fill_pending = 1'b1;
                if (exp_q.size() > 0 && exp_q[0].wb && wb_seen == 0)
                begin
                    $display("miss request for %h went out before the dirty victim was written back",
                             miss_pkt.addr);
                    error_count++;
                end
                if (exp_q.size() > 0 && exp_q[0].miss)
                    compare_field("miss_pkt.addr", 32'(miss_pkt.addr), 32'(exp_q[0].addr));
            end
            if (ret_valid && ret_ack)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("a return for address %h came back with no request outstanding",
                             ret_pkt.addr);
                    error_count++;
                end
                else
                begin
                    head = exp_q.pop_front();
                    compare_field("ret_pkt.data", ret_pkt.data, head.data);
                    compare_field("ret_pkt.addr", 32'(ret_pkt.addr), 32'(head.addr));
                    compare_field("ret_pkt.port", 32'(ret_pkt.port), 32'(head.port));
                    compare_field("miss transfers", miss_seen, 32'(head.miss));
                    compare_field("wb transfers", wb_seen, 32'(head.wb));
                end
                miss_seen = 0;
                wb_seen   = 0;
            end
        end
    end

endmodule

/* tb/tb_cache_bank.sv */
`timescale 1ns/1ps

module tb_cache_bank;

    localparam int NCOL        = 12;
    localparam int CASE_MAX    = 32;
    localparam int REQ_TIMEOUT = 200;
    localparam int RET_TIMEOUT = 400;

    // columns of one line in the cases file
    localparam int C_ID      = 0;
    localparam int C_PORT    = 1;
    localparam int C_CRIT    = 2;
    localparam int C_WRITE   = 3;
    localparam int C_ADDR    = 4;
    localparam int C_DATA    = 5;
    localparam int C_EXP     = 6;
    localparam int C_MISS    = 7;
    localparam int C_WB      = 8;
    localparam int C_WB_ADDR = 9;
    localparam int C_WB_DATA = 10;
    localparam int C_STALL   = 11;

    logic                                                  clk_in;
    logic                                                  rst_n;
    logic [cache_pkg::NUM_INPUT_PORT*cache_pkg::PKT_W-1:0] req_pkt;
    logic [cache_pkg::NUM_INPUT_PORT-1:0]                  req_valid;
    logic [cache_pkg::NUM_INPUT_PORT-1:0]                  req_critical;
    logic [cache_pkg::NUM_INPUT_PORT-1:0]                  req_ack;
    cache_pkg::cache_pkt_t                                 miss_p;
    cache_pkg::cache_pkt_t                                 wb_p;
    cache_pkg::cache_pkt_t                                 fetched_p;
    cache_pkg::cache_pkt_t                                 ret_p;
    logic                                                  miss_valid;
    logic                                                  wb_valid;
    logic                                                  ret_valid;
    logic                                                  fetched_valid;
    logic                                                  fetch_ack;
    logic                                                  miss_ack;
    logic                                                  wb_ack;
    logic                                                  ret_ack;

    // acks of the miss, writeback and return ports in that order
    logic [2:0]  ack_v;
    logic [2:0]  valid_v;
    int          delay_cnt [3];
    int          stall_cnt;
    logic [31:0] case_mem [CASE_MAX*NCOL];
    logic [31:0] mem_q [65536];
    int          num_lines;
    int          tests_run;
    int          tests_failed;
    logic        aborted;

    assign miss_ack = ack_v[0];
    assign wb_ack   = ack_v[1];
    assign ret_ack  = ack_v[2];
    assign valid_v  = {ret_valid, wb_valid, miss_valid};

    cache_bank i_dut (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .req_pkt       (req_pkt),
        .req_valid     (req_valid),
        .req_critical  (req_critical),
        .req_ack       (req_ack),
        .miss_pkt      (miss_p),
        .miss_valid    (miss_valid),
        .miss_ack      (miss_ack),
        .wb_pkt        (wb_p),
        .wb_valid      (wb_valid),
        .wb_ack        (wb_ack),
        .fetched_pkt   (fetched_p),
        .fetched_valid (fetched_valid),
        .fetch_ack     (fetch_ack),
        .ret_pkt       (ret_p),
        .ret_valid     (ret_valid),
        .ret_ack       (ret_ack)
    );

    cache_checker i_checker (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .ret_pkt       (ret_p),
        .ret_valid     (ret_valid),
        .ret_ack       (ret_ack),
        .miss_pkt      (miss_p),
        .miss_valid    (miss_valid),
        .miss_ack      (miss_ack),
        .wb_pkt        (wb_p),
        .wb_valid      (wb_valid),
        .wb_ack        (wb_ack),
        .fetched_valid (fetched_valid),
        .fetch_ack     (fetch_ack)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] cval(input int line, input int col);
        return case_mem[line*NCOL + col];
    endfunction

    // random ack delay of 0 to 3 cycles
    // ret_ack is also held low while stall_cnt runs
    initial
    begin
        ack_v = '0;
        void'($urandom(32'hdee667fc));
        for (int i = 0; i < 3; i++)
            delay_cnt[i] = $urandom % 4;
        forever
        begin
            @(negedge clk_in);
            for (int i = 0; i < 3; i++)
            begin
                if (ack_v[i])
                    ack_v[i] = 1'b0;
                else if (i == 2 && stall_cnt > 0)
                    stall_cnt--;
                else if (valid_v[i])
                begin
                    if (delay_cnt[i] == 0)
                    begin
                        ack_v[i]     = 1'b1;
                        delay_cnt[i] = $urandom % 4;
                    end
                    else
                        delay_cnt[i]--;
                end
            end
        end
    end

    // memory model that takes writebacks and answers each miss with one fetched packet
    initial
    begin
        logic [cache_pkg::ADDR_W-1:0] fill_addr;
        logic                         fill_req;
        logic                         fill_done;
        fetched_valid = 1'b0;
        fetched_p     = '0;
        for (int a = 0; a < 65536; a++)
            mem_q[a] = 32'(a) ^ 32'h5a5a0000;
        forever
        begin
            @(posedge clk_in);
            if (wb_valid && wb_ack)
                mem_q[wb_p.addr] = wb_p.data;
            fill_req  = miss_valid && miss_ack;
            fill_done = fetched_valid && fetch_ack;
            if (fill_req)
                fill_addr = miss_p.addr;
            @(negedge clk_in);
            if (fill_done)
                fetched_valid = 1'b0;
            if (fill_req)
            begin
                fetched_p.addr  = fill_addr;
                fetched_p.data  = mem_q[fill_addr];
                fetched_p.write = 1'b0;
                fetched_p.port  = '0;
                fetched_valid   = 1'b1;
            end
        end
    end

    // presents this port's lines of a test one after another
    task automatic drive_port(input int p, input int first, input int last);
        int                    cycles;
        logic                  acked;
        cache_pkg::cache_pkt_t pkt;
        for (int n = first; n <= last; n++)
        begin
            if (cval(n, C_PORT) == p && !aborted)
            begin
                @(negedge clk_in);
                pkt.addr  = 16'(cval(n, C_ADDR));
                pkt.data  = cval(n, C_DATA);
                pkt.write = cval(n, C_WRITE) != 0;
                // the arbiter stamps the port number, so offer the other one
                pkt.port  = ~1'(p);
                req_pkt[p*cache_pkg::PKT_W +: cache_pkg::PKT_W] = pkt;
                req_critical[p] = cval(n, C_CRIT) != 0;
                req_valid[p]    = 1'b1;
                acked  = 1'b0;
                cycles = 0;
                while (!acked && cycles < REQ_TIMEOUT)
                begin
                    @(posedge clk_in);
                    acked = req_ack[p];
                    cycles++;
                end
                if (!acked)
                begin
                    $display("port %0d: request to %h not acked within %0d cycles",
                             p, pkt.addr, REQ_TIMEOUT);
                    aborted = 1'b1;
                end
            end
        end
        @(negedge clk_in);
        req_valid[p]    = 1'b0;
        req_critical[p] = 1'b0;
    endtask

    task automatic run_test(input int first, input int last);
        int errors_before;
        int cycles;
        int id;
        errors_before = i_checker.error_count;
        id            = cval(first, C_ID);
        stall_cnt     = cval(first, C_STALL);
        // lines of a test are listed in the order the returns must come back
        for (int k = first; k <= last; k++)
        begin
            i_checker.expect_ret(16'(cval(k, C_ADDR)), cval(k, C_EXP), cval(k, C_PORT) != 0,
                                 cval(k, C_MISS) != 0, cval(k, C_WB) != 0,
                                 16'(cval(k, C_WB_ADDR)), cval(k, C_WB_DATA));
        end
        fork
            drive_port(0, first, last);
            drive_port(1, first, last);
        join
        cycles = 0;
        while (!aborted && i_checker.outstanding() != 0 && cycles < RET_TIMEOUT)
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!aborted && i_checker.outstanding() != 0)
        begin
            $display("test %0d: %0d return packets still missing after %0d cycles",
                     id, i_checker.outstanding(), RET_TIMEOUT);
            aborted = 1'b1;
        end
        tests_run++;
        if (!aborted && i_checker.error_count == errors_before)
            $display("test %0d: ok", id);
        else
        begin
            tests_failed++;
            $display("test %0d: FAIL, %0d errors", id, i_checker.error_count - errors_before);
        end
    endtask

    initial
    begin
        int n;
        int last;
        aborted      = 1'b0;
        rst_n        = 1'b0;
        req_pkt      = '0;
        req_valid    = '0;
        req_critical = '0;
        for (int k = 0; k < CASE_MAX*NCOL; k++)
            case_mem[k] = '0;
        $readmemh("tb/cache_cases.txt", case_mem);
        num_lines = 0;
        while (num_lines < CASE_MAX && cval(num_lines, C_ID) != 0)
            num_lines++;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_n = 1'b1;
        if (num_lines == 0)
        begin
            $display("no cases were read from tb/cache_cases.txt");
            aborted = 1'b1;
        end
        n = 0;
        while (n < num_lines && !aborted)
        begin
            last = n;
            while (last + 1 < num_lines && cval(last + 1, C_ID) == cval(n, C_ID))
                last++;
            run_test(n, last);
            n = last + 1;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 i_checker.error_count);
        if (!aborted && tests_failed == 0 && i_checker.error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* vlog.f */
hw/cache_pkg.sv
hw/cache_req_if.sv
hw/intra_bank_arbiter.sv
hw/request_queue.sv
hw/cache_set_array.sv
hw/cache_bank_ctrl.sv
hw/cache_bank.sv
tb/cache_checker.sv
tb/tb_cache_bank.sv
